// File: vlog.f
+incdir+rtl
+incdir+verif
rtl/x25519_pkg.sv
rtl/operand_ram.sv
rtl/mod_alu.sv
rtl/final_seq.sv
rtl/wb_host_if.sv
rtl/x25519_final_top.sv
verif/tb_x25519_final.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the X25519 final step testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_x25519_final -Mdir obj_dir -f vlog.f

# the log decides the result
./obj_dir/Vtb_x25519_final > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "no pass line in sim.log"
    exit 1
fi
echo "simulation ok"

// File: verif/x25519_model.svh
/* reference math for the X25519 final step testbench
   included inside the testbench module body */
`ifndef X25519_MODEL_SVH
`define X25519_MODEL_SVH

// p = 2^255 - 19, own copy
localparam logic [255:0] MODEL_P =
    256'h7fffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffed;

// a * b mod p, lsb first add and double, a below p
function automatic logic [255:0] mod_mul(input logic [255:0] a, input logic [255:0] b);
    logic [256:0] sum;
    logic [256:0] addend;
    sum    = '0;
    addend = {1'b0, a};
    for (int i = 0; i < 256; i++)
    begin
        if (b[i])
        begin
            sum = sum + addend;
            if (sum >= {1'b0, MODEL_P})
                sum = sum - {1'b0, MODEL_P};   // stays below p
        end
        addend = addend << 1;
        if (addend >= {1'b0, MODEL_P})
            addend = addend - {1'b0, MODEL_P};
    end
    return sum[255:0];
endfunction

// base ^ e mod p, right to left
function automatic logic [255:0] mod_pow(input logic [255:0] base, input logic [255:0] e);
    logic [255:0] res;
    logic [255:0] sq;
    res = 256'd1;
    sq  = base;
    for (int i = 0; i < 256; i++)
    begin
        if (e[i])
            res = mod_mul(res, sq);
        sq = mod_mul(sq, sq);
    end
    return res;
endfunction

// byte 0 of the result is the top byte of the input
function automatic logic [255:0] byte_reverse(input logic [255:0] w);
    logic [255:0] r;
    for (int i = 0; i < 32; i++)
        r[8*i +: 8] = w[8*(31-i) +: 8];
    return r;
endfunction

`endif

// File: verif/tb_x25519_final.sv
/* directed testbench for the X25519 final step that drives the wishbone port
   and checks RAM traffic and affine conversion against the model */
`include "x25519_params.svh"

module tb_x25519_final;
    timeunit 1ns;
    timeprecision 1ps;

`include "x25519_model.svh"

    ////////////////////
    // host register map
    localparam logic [7:0] A_CTRL   = 8'h00;
    localparam logic [7:0] A_STATUS = 8'h04;
    localparam logic [7:0] A_STAGE  = 8'h20;   // lane 0 holds the lsb
    localparam logic [7:0] A_CMD    = 8'h40;
    localparam int ACK_LIMIT  = 16;            // cycles per bus access
    localparam int POLL_LIMIT = 100000;        // status reads per run

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack;

    x25519_final_top x25519_final_top_i
    (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    ////////////////////
    // failure reporting
    task automatic abort_run(input string what);
        $display("tests failed");
        $display("%s at %0t ns", what, $time);
        $fatal(1, "stopping at first error");
    endtask

    task automatic value_error(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        $display("tests failed");
        $display("error at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input logic [255:0] got,
                              input logic [255:0] exp);
        assert (got === exp) else value_error(name, got, exp);
    endtask

    ////////////////////
    // wishbone classic master
    task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
        int n;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_i <= dat;
        n = 0;
        @(negedge clk);   // sample away from the drive edge
        while (!wb_ack && n < ACK_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        assert (wb_ack) else abort_run("no ack on a bus write");
        @(posedge clk);
        wb_cyc <= 1'b0;   // drop after ack
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
        int n;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        n = 0;
        @(negedge clk);
        while (!wb_ack && n < ACK_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        assert (wb_ack) else abort_run("no ack on a bus read");
        dat = wb_dat_o;   // valid with ack
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    ////////////////////
    // RAM access through the staging word
    task automatic ram_store(input logic [4:0] addr, input logic [255:0] w);
        for (int i = 0; i < 8; i++)
            wb_write(A_STAGE + 8'(4*i), w[32*i +: 32]);
        wb_write(A_CMD, 32'h100 | 32'(addr));   // bit 8 moves stage to RAM
    endtask

    task automatic ram_fetch(input logic [4:0] addr, output logic [255:0] w);
        logic [31:0] lane;
        wb_write(A_CMD, 32'(addr));   // RAM to stage
        for (int i = 0; i < 8; i++)
        begin
            wb_read(A_STAGE + 8'(4*i), lane);
            w[32*i +: 32] = lane;
        end
    endtask

    function automatic logic [255:0] rand_word();
        logic [255:0] w;
        for (int i = 0; i < 8; i++)
            w[32*i +: 32] = $urandom;
        if (w >= MODEL_P)
            w = w - MODEL_P;
        if (w >= MODEL_P)
            w = w - MODEL_P;   // 2^256 is just over 2p
        return w;
    endfunction

    task automatic wait_done();
        logic [31:0] st;
        int          n;
        n = 0;
        st = '0;
        while (!st[1] && n < POLL_LIMIT)
        begin
            wb_read(A_STATUS, st);
            n++;
        end
        assert (st[1]) else abort_run("timeout waiting for STATUS done");
    endtask

    ////////////////////
    // directed tests
    task automatic test_reset_status();
        logic [31:0] st;
        wb_read(A_STATUS, st);
        check_word("STATUS", 256'(st), 256'd0);   // neither busy nor done
    endtask

    task automatic test_ram_loopback();
        logic [4:0]   addrs [5];
        logic [255:0] words [5];
        logic [255:0] got;
        addrs = '{5'd1, 5'd4, 5'd12, 5'd20, 5'd27};
        for (int i = 0; i < 5; i++)
        begin
            words[i] = rand_word();
            ram_store(addrs[i], words[i]);
        end
        for (int i = 0; i < 5; i++)
        begin
            ram_fetch(addrs[i], got);
            check_word("ram word", got, words[i]);
        end
    endtask

    // load X2 and Z2 then run and check X_KG and done
    task automatic convert_check(input logic [255:0] x2, input logic [255:0] z2,
                                 input logic check_busy);
        logic [255:0] exp;
        logic [255:0] got;
        logic [31:0]  st;
        exp = byte_reverse(mod_mul(x2, mod_pow(z2, MODEL_P - 256'd2)));
        ram_store(`X_ADDR_X2, x2);
        ram_store(`X_ADDR_Z2, z2);
        wb_write(A_CTRL, 32'd1);   // start
        if (check_busy)
        begin
            wb_read(A_STATUS, st);
            check_word("STATUS", 256'(st), 256'd1);   // busy with old done cleared
        end
        wait_done();
        wb_read(A_STATUS, st);
        check_word("STATUS", 256'(st), 256'd2);
        ram_fetch(`X_ADDR_XKG, got);
        check_word("X_KG", got, exp);
    endtask

    task automatic test_unit_z();
        logic [255:0] x2;
        logic [255:0] other;
        logic [255:0] got;
        x2    = rand_word();
        other = rand_word();
        ram_store(5'd3, other);   // untouched slot
        convert_check(x2, 256'd1, 1'b0);
        ram_fetch(`X_ADDR_XKG, got);
        check_word("X_KG", got, byte_reverse(x2));
        ram_fetch(`X_ADDR_X2, got);
        check_word("X2", got, x2);
        ram_fetch(`X_ADDR_Z2, got);
        check_word("Z2", got, 256'd1);
        ram_fetch(5'd3, got);
        check_word("ram word 3", got, other);
    endtask

    initial
    begin
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = '0;
        void'($urandom(81));
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        test_reset_status();
        test_ram_loopback();
        convert_check(rand_word(), rand_word(), 1'b0);
        test_unit_z();
        convert_check(rand_word(), rand_word(), 1'b1);   // back to back

        $display("all tests passed");
        $finish;
    end

endmodule

// File: rtl/x25519_final_top.sv
/* top of the X25519 final step: wishbone host port, operand RAM,
   sequencer and modular alu wired together */
module x25519_final_top
(
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [7:0]  wb_adr,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack
);

    // host side
    logic                seq_start;
    x25519_pkg::addr_t   host_addr;
    logic                host_we;
    x25519_pkg::word_t   host_wd;
    x25519_pkg::word_t   host_rd;

    // sequencer side
    logic                seq_busy;     // also RAM owner select
    logic                seq_done;
    x25519_pkg::addr_t   seq_ra;
    x25519_pkg::addr_t   seq_wa;
    logic                seq_we;
    x25519_pkg::word_t   seq_wd;

    // alu
    x25519_pkg::word_t   rd;
    x25519_pkg::alu_op_e alu_op;
    logic                alu_en;
    logic                alu_vld;
    x25519_pkg::word_t   alu_dat;

    wb_host_if u_host
    (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack    (wb_ack),
        .seq_busy  (seq_busy),
        .seq_done  (seq_done),
        .seq_start (seq_start),
        .host_addr (host_addr),
        .host_we   (host_we),
        .host_wd   (host_wd),
        .host_rd   (host_rd)
    );

    operand_ram u_ram
    (
        .clk       (clk),
        .rst       (rst),
        .sel_seq   (seq_busy),
        .seq_ra    (seq_ra),
        .seq_wa    (seq_wa),
        .seq_we    (seq_we),
        .seq_wd    (seq_wd),
        .host_addr (host_addr),
        .host_we   (host_we),
        .host_wd   (host_wd),
        .rd        (rd),
        .host_rd   (host_rd)
    );

    final_seq u_seq
    (
        .clk       (clk),
        .rst       (rst),
        .seq_start (seq_start),
        .alu_vld   (alu_vld),
        .alu_dat   (alu_dat),
        .seq_busy  (seq_busy),
        .seq_done  (seq_done),
        .alu_op    (alu_op),
        .alu_en    (alu_en),
        .seq_ra    (seq_ra),
        .seq_wa    (seq_wa),
        .seq_we    (seq_we),
        .seq_wd    (seq_wd)
    );

    mod_alu u_alu
    (
        .clk       (clk),
        .rst       (rst),
        .alu_en    (alu_en),
        .alu_op    (alu_op),
        .rd        (rd),
        .alu_vld   (alu_vld),
        .alu_dat   (alu_dat)
    );

endmodule

// File: rtl/wb_host_if.sv
/* wishbone classic slave for the final step: control, status, staging word
   and a CMD register that moves the staging word to or from the operand RAM */
`include "x25519_params.svh"

module wb_host_if
(
    input  logic              clk,
    input  logic              rst,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [7:0]        wb_adr,     // byte address
    input  logic [31:0]       wb_dat_i,
    output logic [31:0]       wb_dat_o,
    output logic              wb_ack,
    input  logic              seq_busy,
    input  logic              seq_done,
    output logic              seq_start,
    output x25519_pkg::addr_t host_addr,
    output logic              host_we,
    output x25519_pkg::word_t host_wd,
    input  x25519_pkg::word_t host_rd
);

    ////////////////////
    // register map
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_STATUS = 8'h04;
    localparam logic [7:0] REG_CMD    = 8'h40;
    localparam logic [2:0] STAGE_PAGE = 3'b001;   // 0x20-0x3c

    logic              req;         // new cycle, not yet acked
    logic              wr;
    logic              ctrl_hit;
    logic              cmd_hit;
    logic              stage_hit;
    logic [2:0]        lane;        // 32-bit lane of staging word
    logic [31:0]       rdata;
    logic              done_r;      // sticky done
    x25519_pkg::word_t stage;

    assign req       = wb_cyc && wb_stb && !wb_ack;
    assign wr        = req && wb_we;
    assign ctrl_hit  = (wb_adr == REG_CTRL);
    assign cmd_hit   = (wb_adr == REG_CMD);
    assign stage_hit = (wb_adr[7:5] == STAGE_PAGE);
    assign lane      = wb_adr[4:2];

    // CMD bits 4:0 address the RAM, bit 8 picks the direction
    assign host_addr = wb_dat_i[`X_AWID-1:0];
    assign host_we   = wr && cmd_hit && wb_dat_i[8];   // lands with ack
    assign host_wd   = stage;

    always_comb
    begin
        rdata = '0;
        if (wb_adr == REG_STATUS)
            rdata = {30'd0, done_r, seq_busy};
        else if (stage_hit)
            rdata = stage[{lane, 5'd0} +: 32];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_ack    <= 1'b0;
            seq_start <= 1'b0;
            done_r    <= 1'b0;
        end
        else
        begin
            wb_ack    <= req;   // single cycle, master drops stb after it
            seq_start <= wr && ctrl_hit && wb_dat_i[0] && !seq_busy;
            if (wr && ctrl_hit && wb_dat_i[0] && !seq_busy)
                done_r <= 1'b0;   // new run
            else if (seq_done)
                done_r <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req)
            wb_dat_o <= rdata;   // valid with ack
        if (wr && stage_hit)
            stage[{lane, 5'd0} +: 32] <= wb_dat_i;
        else if (wr && cmd_hit && !wb_dat_i[8])
            stage <= host_rd;   // RAM to staging
    end

    // classic handshake, master holds cyc and stb until ack
    a_ack_in_cycle : assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("ack outside a bus cycle");

endmodule

// File: rtl/final_seq.sv
/* final-step sequencer, turns ladder output X2, Z2 into affine X_KG
   host start kicks it; done pulses after X_KG is written byte reversed */
`include "x25519_params.svh"

module final_seq
(
    input  logic                clk,
    input  logic                rst,
    input  logic                seq_start,
    input  logic                alu_vld,
    input  x25519_pkg::word_t   alu_dat,
    output logic                seq_busy,
    output logic                seq_done,
    output x25519_pkg::alu_op_e alu_op,
    output logic                alu_en,
    output x25519_pkg::addr_t   seq_ra,
    output x25519_pkg::addr_t   seq_wa,
    output logic                seq_we,
    output x25519_pkg::word_t   seq_wd
);

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_FETCH,    // read z2
        S_POW,      // inversion running
        S_POW2,     // store inverse, read x2, issue mul
        S_RSLT,     // product running
        S_DONE      // store swapped product
    } state_e;

    state_e            state;
    x25519_pkg::word_t res;       // alu result caught on vld
    x25519_pkg::word_t res_rev;   // little endian byte order

    always_comb
    begin
        for (int i = 0; i < `X_WID / 8; i++)
            res_rev[8*i +: 8] = res[`X_WID - 8*(i+1) +: 8];
    end

    ////////////////////
    // state
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= S_IDLE;
            seq_busy <= 1'b0;
            seq_done <= 1'b0;
        end
        else
        begin
            seq_done <= (state == S_DONE);
            if (seq_start && (state == S_IDLE))
                seq_busy <= 1'b1;
            else if (seq_done)
                seq_busy <= 1'b0;   // held through the final write
            case (state)
                S_IDLE  : if (seq_start) state <= S_FETCH;
                S_FETCH : state <= S_POW;
                S_POW   : if (alu_vld) state <= S_POW2;
                S_POW2  : state <= S_RSLT;
                S_RSLT  : if (alu_vld) state <= S_DONE;
                default : state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (alu_vld)
            res <= alu_dat;
    end

    ////////////////////
    // alu and RAM drive, all one cycle behind the state
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            alu_en <= 1'b0;
            alu_op <= x25519_pkg::OP_NONE;
            seq_we <= 1'b0;
            seq_wa <= `X_ADDR_DBG;
            seq_ra <= `X_ADDR_ZERO;
        end
        else
        begin
            alu_en <= (state == S_FETCH) || (state == S_POW2);
            alu_op <= (state == S_FETCH) ? x25519_pkg::OP_INV :
                      (state == S_POW2)  ? x25519_pkg::OP_MUL :
                                           x25519_pkg::OP_NONE;
            seq_we <= (state == S_POW2) || (state == S_DONE);
            seq_wa <= ((state == S_POW2) || (state == S_DONE)) ? `X_ADDR_XKG
                                                                : `X_ADDR_DBG;
            seq_ra <= ((state == S_FETCH) || (state == S_POW))  ? `X_ADDR_Z2 :
                      ((state == S_POW2)  || (state == S_RSLT)) ? `X_ADDR_X2 :
                                                                  `X_ADDR_ZERO;
        end
    end

    always_ff @(posedge clk)
    begin
        seq_wd <= (state == S_DONE) ? res_rev : res;   // inverse first, then X_KG
    end

    // alu only answers what this sequencer issued
    a_vld_expected : assert property (@(posedge clk) disable iff (rst)
        alu_vld |-> ((state == S_POW) || (state == S_RSLT)))
        else $error("alu result outside POW or RSLT");

endmodule

// File: rtl/mod_alu.sv
/* modular alu of the final step: bit-serial multiply mod p, and inversion as
   square-and-multiply over p-2; the accumulator carries over between ops */
`include "x25519_params.svh"

module mod_alu
(
    input  logic                clk,
    input  logic                rst,
    input  logic                alu_en,     // issue pulse
    input  x25519_pkg::alu_op_e alu_op,
    input  x25519_pkg::word_t   rd,
    output logic                alu_vld,
    output x25519_pkg::word_t   alu_dat
);

    localparam x25519_pkg::word_t P_M2 = x25519_pkg::P - 2;   // inversion exponent
    localparam logic [7:0] TOP_BIT   = 8'd253;   // bit 254 is the loaded base
    localparam logic [7:0] LAST_STEP = 8'd255;

    // msb-first double-and-add step, r and a below p
    function automatic x25519_pkg::word_t dbl_add(input x25519_pkg::word_t r,
                                                  input x25519_pkg::word_t a,
                                                  input logic b);
        logic [`X_WID:0] t;
        t = {r, 1'b0};
        if (t >= {1'b0, x25519_pkg::P})
            t = t - {1'b0, x25519_pkg::P};
        if (b)
            t = t + {1'b0, a};
        if (t >= {1'b0, x25519_pkg::P})
            t = t - {1'b0, x25519_pkg::P};
        return t[`X_WID-1:0];
    endfunction

    x25519_pkg::word_t acc;     // accumulator
    x25519_pkg::word_t base;    // inversion base
    x25519_pkg::word_t opv;     // operand folded below p
    x25519_pkg::word_t m_a;     // multiplicand
    x25519_pkg::word_t m_sh;    // multiplier, shifts out msb first
    x25519_pkg::word_t m_r;     // partial product
    x25519_pkg::word_t m_nxt;
    x25519_pkg::word_t ld_a;
    x25519_pkg::word_t ld_b;
    logic              ld_go;   // start a multiply this edge
    logic              run;
    logic              fin;     // last step of a multiply
    logic              inv;     // walking the exponent
    logic              sq;      // current multiply is a square
    logic              e_bit;
    logic [7:0]        cnt;
    logic [7:0]        idx;     // exponent bit

    assign opv     = (rd >= x25519_pkg::P) ? rd - x25519_pkg::P : rd;   // single fold
    assign m_nxt   = dbl_add(m_r, m_a, m_sh[`X_WID-1]);
    assign fin     = run && (cnt == LAST_STEP);
    assign e_bit   = P_M2[idx];
    assign alu_dat = acc;

    ////////////////////
    // next multiply
    always_comb
    begin
        ld_go = 1'b0;
        ld_a  = m_nxt;
        ld_b  = m_nxt;   // square of the last result
        if (alu_en)
        begin
            ld_go = (alu_op == x25519_pkg::OP_MUL) || (alu_op == x25519_pkg::OP_INV);
            ld_a  = (alu_op == x25519_pkg::OP_MUL) ? acc : opv;
            ld_b  = opv;
        end
        else if (fin && inv)
        begin
            if (sq && e_bit)
            begin
                ld_go = 1'b1;
                ld_b  = base;   // multiply step
            end
            else
            begin
                ld_go = (idx != 8'd0);   // next square unless exponent used up
            end
        end
    end

    ////////////////////
    // control
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            run     <= 1'b0;
            cnt     <= 8'd0;
            inv     <= 1'b0;
            sq      <= 1'b0;
            idx     <= 8'd0;
            alu_vld <= 1'b0;
        end
        else
        begin
            alu_vld <= fin && !ld_go;
            if (ld_go)
            begin
                run <= 1'b1;
                cnt <= 8'd1;   // load edge does step one
            end
            else if (fin)
            begin
                run <= 1'b0;
            end
            else if (run)
            begin
                cnt <= cnt + 8'd1;
            end
            if (alu_en)
            begin
                inv <= (alu_op == x25519_pkg::OP_INV);
                sq  <= 1'b1;
                idx <= TOP_BIT;
            end
            else if (fin && inv)
            begin
                if (sq && e_bit)
                begin
                    sq <= 1'b0;
                end
                else
                begin
                    sq  <= 1'b1;
                    idx <= idx - 8'd1;
                end
            end
        end
    end

    ////////////////////
    // datapath
    always_ff @(posedge clk)
    begin
        if (ld_go)
        begin
            m_a  <= ld_a;
            m_sh <= ld_b << 1;
            m_r  <= dbl_add('0, ld_a, ld_b[`X_WID-1]);
        end
        else if (run)
        begin
            m_r  <= m_nxt;
            m_sh <= m_sh << 1;
        end
        if (fin)
            acc <= m_nxt;
        if (alu_en && (alu_op == x25519_pkg::OP_INV))
            base <= opv;
    end

    // sequencer waits for vld before the next issue
    a_no_issue_busy : assert property (@(posedge clk) disable iff (rst)
        alu_en |-> !run)
        else $error("alu issued while an operation is running");

endmodule

// File: rtl/operand_ram.sv
/* 32 x 256 operand register file shared by host and final-step sequencer
   sel_seq high hands read mux and write port to the sequencer */
`include "x25519_params.svh"

module operand_ram
(
    input  logic              clk,
    input  logic              rst,
    input  logic              sel_seq,      // sequencer owns the RAM
    input  x25519_pkg::addr_t seq_ra,
    input  x25519_pkg::addr_t seq_wa,
    input  logic              seq_we,
    input  x25519_pkg::word_t seq_wd,
    input  x25519_pkg::addr_t host_addr,
    input  logic              host_we,
    input  x25519_pkg::word_t host_wd,
    output x25519_pkg::word_t rd,           // to alu
    output x25519_pkg::word_t host_rd
);

    x25519_pkg::word_t mem [0:(1 << `X_AWID)-1];
    x25519_pkg::addr_t ra;
    x25519_pkg::addr_t wa;
    x25519_pkg::word_t wd;
    logic              we;

    // client select
    assign ra = sel_seq ? seq_ra : host_addr;
    assign wa = sel_seq ? seq_wa : host_addr;
    assign wd = sel_seq ? seq_wd : host_wd;
    assign we = sel_seq ? seq_we : host_we;

    assign rd      = mem[ra];          // async read
    assign host_rd = mem[host_addr];   // host view, always live

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[wa] <= wd;
        end
    end

    // sequencer must stay quiet once it has released the RAM
    a_one_writer : assert property (@(posedge clk) disable iff (rst)
        !sel_seq |-> !(seq_we && host_we))
        else $error("sequencer and host write in the same cycle");

endmodule

// File: rtl/x25519_pkg.sv
/* shared types and the field prime for the X25519 final step
   compiled first; modules reach these by scoped name */
`include "x25519_params.svh"

package x25519_pkg;

    typedef logic [`X_WID-1:0]  word_t;    // one field element
    typedef logic [`X_AWID-1:0] addr_t;    // operand RAM slot

    // alu opcodes, same encodings as the full engine
    typedef enum logic [3:0]
    {
        OP_NONE = 4'd0,
        OP_MUL  = 4'd1,    // acc = acc * operand mod p
        OP_INV  = 4'd2     // acc = operand ^ (p-2) mod p
    } alu_op_e;

    // p = 2^255 - 19
    localparam word_t P =
        256'h7fffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffed;

endpackage

// File: rtl/x25519_params.svh
/* widths and operand RAM slot map of the X25519 final step
   included by the package and by any module that names a RAM slot or width */
`ifndef X25519_PARAMS_SVH
`define X25519_PARAMS_SVH

////////////////////
// datapath widths
`define X_WID   256     // one field word
`define X_AWID  5       // 32 RAM slots

////////////////////
// operand RAM slots left behind by the ladder
`define X_ADDR_X2    5'd7     // projective x
`define X_ADDR_Z2    5'd8     // projective z
`define X_ADDR_XKG   5'd15    // affine result, little endian bytes

// housekeeping slots
`define X_ADDR_ZERO  5'd18    // zero constant, idle read address
`define X_ADDR_DBG   5'd30    // write address parks here

`endif
